// ==== design/lspcPkg.sv ====
`include "lspc_macros.svh"

package lspcPkg;

	// VRAM word address and word
	typedef logic [`VRAM_AW-1:0] vramAddrT;
	typedef logic [`VRAM_DW-1:0] vramDataT;

	// Renderer side
	typedef logic [8:0] sprNbT;	// Sprite number
	typedef logic [4:0] tileIdxT;	// Tile within a sprite

	typedef logic [8:0] lineT;	// Up to 264 lines

	// Slot owner for each cycle of the pattern
	typedef enum logic [1:0]
	{
		SLOT_SPR0 = `SLOT_NUM_SPR0,
		SLOT_SPR1 = `SLOT_NUM_SPR1,
		SLOT_CPU = `SLOT_NUM_CPU,
		SLOT_FIX = `SLOT_NUM_FIX
	} slotT;

endpackage

// ==== design/lspc_macros.svh ====
`ifndef LSPC_MACROS_SVH
`define LSPC_MACROS_SVH

// Slow VRAM geometry
`define VRAM_AW 15
`define VRAM_DW 16
`define FIX_BASE 15'h7000	// Fix map lives in the top 4K words

// Slot numbers of the four cycle pattern
`define SLOT_NUM_SPR0 2'd0	// Sprite map word 0
`define SLOT_NUM_SPR1 2'd1	// Sprite map word 1
`define SLOT_NUM_CPU 2'd2	// Host access
`define SLOT_NUM_FIX 2'd3	// Fix map word

// APB register offsets
`define APB_AW 4
`define REG_VRAMADDR 4'h0	// Pointer load
`define REG_VRAMRW 4'h4	// Data at pointer
`define REG_VRAMMOD 4'h8	// Pointer step after write

`define LINE_CYCLES 384	// CLK_24M cycles per line
`define LINE_COUNT 264	// Lines per frame
`define ACK_LIMIT 8	// Longest VRAMRW wait in cycles

`endif

// ==== design/slowCycle.sv ====
`include "lspc_macros.svh"

module slowCycle (
	input  logic CLK_24M,
	input  logic rstN,

	input  lspcPkg::slotT slot,
	input  lspcPkg::lineT vCount,

	// Renderer side
	input  lspcPkg::sprNbT sprNb,
	input  lspcPkg::tileIdxT sprTileIdx,
	input  logic [5:0] fixMapCol,
	output logic [19:0] sprTileNb,
	output logic [7:0] sprAttrPal,
	output logic [1:0] sprAttrAa,
	output logic [1:0] sprAttrFlip,
	output logic [11:0] fixTileNb,
	output logic [3:0] fixPalNb,

	// Host side
	input  logic ptrLoad,
	input  lspcPkg::vramAddrT ptrValue,
	input  lspcPkg::vramAddrT vramMod,
	input  logic cpuReq,
	input  logic cpuWrite,
	input  lspcPkg::vramDataT cpuWrData,
	output logic cpuAck,
	output lspcPkg::vramDataT cpuRdData,
	output lspcPkg::vramAddrT ptr,

	// RAM port
	output lspcPkg::vramAddrT ramAddr,
	output logic ramWrEn,
	output lspcPkg::vramDataT ramWrData,
	input  lspcPkg::vramDataT ramRdData
);
	import lspcPkg::*;

	slotT slotD;	// Slot whose word is now on ramRdData
	logic cpuServed;	// Request already taken this round
	logic cpuGrant;
	logic [3:0] sprTileNbU;
	logic [15:0] sprTileNbL;
	vramAddrT sprAddr0;
	vramAddrT sprAddr1;
	vramAddrT fixAddr;
	logic [4:0] fixLine;

	// Fix rows are 8 lines high
	assign fixLine = vCount[7:3];

	// Sprite map entry is two words, LSB selects the word
	assign sprAddr0 = {sprNb, sprTileIdx, 1'b0};
	assign sprAddr1 = {sprNb, sprTileIdx, 1'b1};
	assign fixAddr = `FIX_BASE | {4'b0000, fixMapCol, fixLine};	// 111 0CCC CCCL LLLL

	assign cpuGrant = (slot == SLOT_CPU) && cpuReq && !cpuServed;

	// Address mux by slot owner
	always_comb
	begin
		case (slot)
			SLOT_SPR0: ramAddr = sprAddr0;
			SLOT_SPR1: ramAddr = sprAddr1;
			SLOT_CPU: ramAddr = ptr;
			default: ramAddr = fixAddr;
		endcase
	end

	assign ramWrEn = cpuGrant && cpuWrite;	// Only ever in slot CPU
	assign ramWrData = cpuWrData;
	assign cpuRdData = ramRdData;	// CPU word is on the bus during slot FIX

	// Slot of the word coming back from the RAM
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			slotD <= SLOT_CPU;	// Nothing to latch in the first cycle
		else
			slotD <= slot;
	end

	// Host request, one grant per request
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
		begin
			cpuAck <= 1'b0;
			cpuServed <= 1'b0;
		end
		else
		begin
			cpuAck <= cpuGrant;	// High during the following FIX slot
			if (cpuGrant)
				cpuServed <= 1'b1;
			else if (!cpuReq)
				cpuServed <= 1'b0;	// Requester let go
		end
	end

	// Address pointer
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			ptr <= '0;
		else if (ptrLoad)
			ptr <= ptrValue;
		else if (cpuAck && cpuWrite)
			ptr <= ptr + vramMod;	// Wraps modulo 32K
	end

	// Render latches, strobed by the delayed slot
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
		begin
			sprTileNbL <= '0;
			sprTileNbU <= '0;
			sprAttrPal <= '0;
			sprAttrAa <= '0;
			sprAttrFlip <= '0;
			fixTileNb <= '0;
			fixPalNb <= '0;
		end
		else
		begin
			case (slotD)
				SLOT_SPR0: sprTileNbL <= ramRdData;	// Low tile number
				SLOT_SPR1:
				begin
					sprAttrPal <= ramRdData[15:8];
					sprTileNbU <= ramRdData[7:4];	// Upper tile bits
					sprAttrAa <= ramRdData[3:2];	// Auto animation
					sprAttrFlip <= ramRdData[1:0];
				end
				SLOT_FIX:
				begin
					fixTileNb <= ramRdData[11:0];
					fixPalNb <= ramRdData[15:12];
				end
				default: ;	// CPU word goes out on cpuRdData
			endcase
		end
	end

	assign sprTileNb = {sprTileNbU, sprTileNbL};

endmodule

// ==== design/slowTiming.sv ====
`include "lspc_macros.svh"

module slowTiming (
	input  logic CLK_24M,
	input  logic rstN,
	output lspcPkg::slotT slot,
	output lspcPkg::lineT vCount
);
	import lspcPkg::*;

	logic [8:0] hCount;	// Cycle within the line
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == 9'(`LINE_CYCLES - 1));
	assign frameEnd = (vCount == lineT'(`LINE_COUNT - 1));

	// Slot runs freely, SPR0 first after reset
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			slot <= SLOT_SPR0;
		else
			slot <= slotT'(slot + 2'd1);	// Wraps FIX -> SPR0
	end

	// Horizontal cycle counter
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			hCount <= '0;
		else if (lineEnd)
			hCount <= '0;
		else
			hCount <= hCount + 9'd1;
	end

	// Line counter steps at the end of each line
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			vCount <= '0;
		else if (lineEnd)
		begin
			if (frameEnd)
				vCount <= '0;	// Back to the first line
			else
				vCount <= vCount + lineT'(1);
		end
	end

endmodule

// ==== design/slowVram.sv ====
`include "lspc_macros.svh"

module slowVram (
	input  logic CLK_24M,
	input  lspcPkg::vramAddrT ramAddr,
	input  logic ramWrEn,
	input  lspcPkg::vramDataT ramWrData,
	output lspcPkg::vramDataT ramRdData
);
	import lspcPkg::*;

	// 32K words
	vramDataT mem [0:(1 << `VRAM_AW) - 1];

	// Single port, read before write
	always_ff @(posedge CLK_24M)
	begin
		if (ramWrEn)
			mem[ramAddr] <= ramWrData;
		ramRdData <= mem[ramAddr];	// Old word on a write cycle
	end

endmodule

// ==== design/slowVramTop.sv ====
`include "lspc_macros.svh"

module slowVramTop (
	input  logic CLK_24M,
	input  logic rstN,

	// APB
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  lspcPkg::vramDataT pwdata,
	output lspcPkg::vramDataT prdata,
	output logic pready,

	// Renderer
	input  lspcPkg::sprNbT sprNb,
	input  lspcPkg::tileIdxT sprTileIdx,
	input  logic [5:0] fixMapCol,
	output logic [19:0] sprTileNb,
	output logic [7:0] sprAttrPal,
	output logic [1:0] sprAttrAa,
	output logic [1:0] sprAttrFlip,
	output logic [11:0] fixTileNb,
	output logic [3:0] fixPalNb,

	output lspcPkg::lineT vCount
);
	import lspcPkg::*;

	slotT slot;

	// Host path between APB slave and arbiter
	logic ptrLoad;
	vramAddrT ptrValue;
	vramAddrT vramMod;
	logic cpuReq;
	logic cpuWrite;
	vramDataT cpuWrData;
	logic cpuAck;
	vramDataT cpuRdData;
	vramAddrT ptr;

	// RAM port
	vramAddrT ramAddr;
	logic ramWrEn;
	vramDataT ramWrData;
	vramDataT ramRdData;

	slowTiming i_timing (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.slot(slot), .vCount(vCount)
	);

	slowCycle i_cycle (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.slot(slot), .vCount(vCount),
		.sprNb(sprNb), .sprTileIdx(sprTileIdx), .fixMapCol(fixMapCol),
		.sprTileNb(sprTileNb), .sprAttrPal(sprAttrPal), .sprAttrAa(sprAttrAa),
		.sprAttrFlip(sprAttrFlip), .fixTileNb(fixTileNb), .fixPalNb(fixPalNb),
		.ptrLoad(ptrLoad), .ptrValue(ptrValue), .vramMod(vramMod),
		.cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuWrData(cpuWrData),
		.cpuAck(cpuAck), .cpuRdData(cpuRdData), .ptr(ptr),
		.ramAddr(ramAddr), .ramWrEn(ramWrEn), .ramWrData(ramWrData),
		.ramRdData(ramRdData)
	);

	slowVram i_vram (
		.CLK_24M(CLK_24M),
		.ramAddr(ramAddr), .ramWrEn(ramWrEn),
		.ramWrData(ramWrData), .ramRdData(ramRdData)
	);

	vramApb i_apb (
		.CLK_24M(CLK_24M), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.ptrLoad(ptrLoad), .ptrValue(ptrValue), .vramMod(vramMod),
		.cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuWrData(cpuWrData),
		.cpuAck(cpuAck), .cpuRdData(cpuRdData), .ptr(ptr)
	);

endmodule

// ==== design/vramApb.sv ====
`include "lspc_macros.svh"

module vramApb (
	input  logic CLK_24M,
	input  logic rstN,

	// APB slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [`APB_AW-1:0] paddr,
	input  lspcPkg::vramDataT pwdata,
	output lspcPkg::vramDataT prdata,
	output logic pready,

	// To the slot arbiter
	output logic ptrLoad,
	output lspcPkg::vramAddrT ptrValue,
	output lspcPkg::vramAddrT vramMod,
	output logic cpuReq,
	output logic cpuWrite,
	output lspcPkg::vramDataT cpuWrData,
	input  logic cpuAck,
	input  lspcPkg::vramDataT cpuRdData,
	input  lspcPkg::vramAddrT ptr
);
	import lspcPkg::*;

	logic selAddr;
	logic selRw;
	logic selMod;
	logic access;	// APB access phase
	logic rwDone;	// Arbiter acknowledged the VRAMRW access
	vramDataT rdLatch;

	// Register decode
	assign selAddr = (paddr == `REG_VRAMADDR);
	assign selRw = (paddr == `REG_VRAMRW);
	assign selMod = (paddr == `REG_VRAMMOD);

	assign access = psel && penable;

	// Plain registers finish at once, VRAMRW waits for the slot
	assign pready = access && (!selRw || rwDone);

	assign ptrLoad = access && pwrite && selAddr;	// Single cycle, pready is immediate
	assign ptrValue = pwdata[`VRAM_AW-1:0];

	// Raised from the setup phase, dropped once acknowledged
	assign cpuReq = psel && selRw && !rwDone;
	assign cpuWrite = pwrite;	// Stable for the whole transfer
	assign cpuWrData = pwdata;

	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			rwDone <= 1'b0;
		else if (pready)
			rwDone <= 1'b0;	// Transfer ends this cycle
		else if (cpuAck)
			rwDone <= 1'b1;
	end

	// Read word from slot CPU
	always_ff @(posedge CLK_24M)
	begin
		if (cpuAck && !cpuWrite)
			rdLatch <= cpuRdData;
	end

	// VRAMMOD
	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			vramMod <= '0;
		else if (access && pwrite && selMod)
			vramMod <= pwdata[`VRAM_AW-1:0];
	end

	// Read mux
	always_comb
	begin
		if (selAddr)
			prdata = vramDataT'(ptr);	// Pointer, 15 bits
		else if (selMod)
			prdata = vramDataT'(vramMod);
		else if (selRw)
			prdata = rdLatch;
		else
			prdata = '0;	// Unmapped offset
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the slow VRAM testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module slowVramTb -f slowVram.f -o slowVramSim || exit 1
simOut="$(./obj_dir/slowVramSim)"
echo "$simOut"
echo "$simOut" | grep -qx "Regression passed" && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

// ==== slowVram.f ====
+incdir+design
design/lspcPkg.sv
design/slowTiming.sv
design/slowVram.sv
design/slowCycle.sv
design/vramApb.sv
design/slowVramTop.sv
testbench/slowVram_assertions.sv
testbench/slowVramTb.sv

// ==== testbench/slowVramTb.sv ====
`include "lspc_macros.svh"

module slowVramTb;
	import lspcPkg::*;

	localparam int burstLen = 16;
	localparam int sprEntries = 6;
	localparam int fixRows = 32;	// Every row of one fix column
	// Reset readback, registers, burst, sprite entries, fix column
	localparam int plannedAccesses = 5 + (3 + 3 * burstLen) + (1 + 3 * sprEntries) + (2 + fixRows);
	localparam int watchdogCycles = plannedAccesses * 16 + `LINE_CYCLES * `LINE_COUNT;

	logic CLK_24M;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_AW-1:0] paddr;
	vramDataT pwdata;
	vramDataT prdata;
	logic pready;
	sprNbT sprNb;
	tileIdxT sprTileIdx;
	logic [5:0] fixMapCol;
	logic [19:0] sprTileNb;
	logic [7:0] sprAttrPal;
	logic [1:0] sprAttrAa;
	logic [1:0] sprAttrFlip;
	logic [11:0] fixTileNb;
	logic [3:0] fixPalNb;
	lineT vCount;

	vramDataT shadow [0:(1 << `VRAM_AW) - 1];	// Expected VRAM contents
	integer seed = 32'hda7d;
	int errCount = 0;

	slowVramTop i_dut (.*);

	initial CLK_24M = 1'b0;
	always #5 CLK_24M = ~CLK_24M;

	task automatic checkValue(input string sigName, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
		begin
			errCount++;
			$display("mismatch %s: got %h, expected %h", sigName, got, expected);
		end
	endtask

	// One APB transfer, back to back with the next one
	task automatic apbAccess(input logic isWrite, input logic [`APB_AW-1:0] regOff,
		input vramDataT wrData, output vramDataT rdData);
		@(posedge CLK_24M);
		psel <= 1'b1;	// Setup phase
		penable <= 1'b0;
		pwrite <= isWrite;
		paddr <= regOff;
		pwdata <= wrData;
		@(posedge CLK_24M);
		penable <= 1'b1;
		@(negedge CLK_24M);
		while (!pready)
			@(negedge CLK_24M);	// Slave stalls VRAMRW
		rdData = prdata;
	endtask

	task automatic apbWrite(input logic [`APB_AW-1:0] regOff, input vramDataT wrData);
		vramDataT unused;
		apbAccess(1'b1, regOff, wrData, unused);
	endtask

	task automatic apbRead(input logic [`APB_AW-1:0] regOff, output vramDataT rdData);
		apbAccess(1'b0, regOff, pwdata, rdData);	// pwdata left as it was
	endtask

	task automatic apbIdle();
		@(posedge CLK_24M);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Fix base, then column, then row
	function automatic vramAddrT fixEntryAddr(input logic [5:0] col, input logic [4:0] row);
		fixEntryAddr = vramAddrT'(`FIX_BASE + (int'(col) << 5) + int'(row));
	endfunction

	initial
	begin
		vramAddrT startPtr;
		vramAddrT modStep;
		vramAddrT addr;
		vramDataT data;
		vramDataT w0;
		vramDataT w1;
		vramDataT rd;
		sprNbT nb;
		tileIdxT idx;
		logic [5:0] col;
		lineT prevLine;
		lineT expLine;
		int lineCycles;
		int k;

		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		sprNb = '0;
		sprTileIdx = '0;
		fixMapCol = '0;

		for (k = 0; k < 10; k++)
		begin
			@(negedge CLK_24M);
			checkValue("pready", 32'(pready), 32'h0);
			checkValue("sprTileNb", 32'(sprTileNb), 32'h0);
			checkValue("sprAttrPal", 32'(sprAttrPal), 32'h0);
			checkValue("sprAttrAa", 32'(sprAttrAa), 32'h0);
			checkValue("sprAttrFlip", 32'(sprAttrFlip), 32'h0);
			checkValue("fixTileNb", 32'(fixTileNb), 32'h0);
			checkValue("fixPalNb", 32'(fixPalNb), 32'h0);
		end
		@(posedge CLK_24M);
		rstN <= 1'b1;
		apbRead(`REG_VRAMADDR, rd);
		checkValue("prdata VRAMADDR", 32'(rd), 32'h0);

		// Register readback
		data = vramDataT'($random(seed)) & 16'h7fff;
		apbWrite(`REG_VRAMMOD, data);
		apbRead(`REG_VRAMMOD, rd);
		checkValue("prdata VRAMMOD", 32'(rd), 32'(data));
		apbWrite(`REG_VRAMADDR, 16'hffff);
		apbRead(`REG_VRAMADDR, rd);
		checkValue("prdata VRAMADDR", 32'(rd), 32'h7fff);

		// Modulo burst
		startPtr = vramAddrT'($random(seed));
		modStep = vramAddrT'($random(seed));
		apbWrite(`REG_VRAMADDR, 16'(startPtr));
		apbWrite(`REG_VRAMMOD, 16'(modStep));
		addr = startPtr;
		for (k = 0; k < burstLen; k++)
		begin
			data = vramDataT'($random(seed));
			apbWrite(`REG_VRAMRW, data);
			shadow[addr] = data;
			addr = addr + modStep;	// 15 bits wrap at 32K
		end
		apbRead(`REG_VRAMADDR, rd);
		checkValue("ptr after burst", 32'(rd),
			32'((int'(startPtr) + burstLen * int'(modStep)) % (1 << `VRAM_AW)));
		for (k = 0; k < burstLen; k++)
		begin
			addr = vramAddrT'((int'(startPtr) + k * int'(modStep)) % (1 << `VRAM_AW));
			apbWrite(`REG_VRAMADDR, 16'(addr));
			apbRead(`REG_VRAMRW, rd);
			checkValue("prdata VRAMRW", 32'(rd), 32'(shadow[addr]));
		end

		// Sprite map entries, two words each
		apbWrite(`REG_VRAMMOD, 16'h0001);
		for (k = 0; k < sprEntries; k++)
		begin
			nb = sprNbT'($random(seed));
			idx = tileIdxT'($random(seed));
			addr = vramAddrT'({nb, idx, 1'b0});
			w0 = vramDataT'($random(seed));
			w1 = vramDataT'($random(seed));
			apbWrite(`REG_VRAMADDR, 16'(addr));
			apbWrite(`REG_VRAMRW, w0);
			apbWrite(`REG_VRAMRW, w1);
			shadow[addr] = w0;
			shadow[addr + 1] = w1;
			apbIdle();
			sprNb <= nb;
			sprTileIdx <= idx;
			repeat (8) @(negedge CLK_24M);
			checkValue("sprTileNb", 32'(sprTileNb), 32'({w1[7:4], w0}));
			checkValue("sprAttrPal", 32'(sprAttrPal), 32'(w1[15:8]));
			checkValue("sprAttrAa", 32'(sprAttrAa), 32'(w1[3:2]));
			checkValue("sprAttrFlip", 32'(sprAttrFlip), 32'(w1[1:0]));
		end

		// Whole fix column, then one frame of lines
		col = 6'($random(seed));
		apbWrite(`REG_VRAMADDR, 16'(fixEntryAddr(col, 5'd0)));
		for (k = 0; k < fixRows; k++)
		begin
			data = vramDataT'($random(seed));
			apbWrite(`REG_VRAMRW, data);
			shadow[fixEntryAddr(col, 5'(k))] = data;
		end
		apbIdle();
		fixMapCol <= col;
		@(negedge CLK_24M);
		prevLine = vCount;
		lineCycles = 0;
		for (k = 0; k < `LINE_COUNT; k++)
		begin
			do
			begin
				@(negedge CLK_24M);
				lineCycles++;
			end
			while (vCount == prevLine);
			if (k > 0)
				checkValue("vCount line length", 32'(lineCycles), 32'(`LINE_CYCLES));
			expLine = lineT'((int'(prevLine) + 1) % `LINE_COUNT);	// Wraps after the last line
			checkValue("vCount", 32'(vCount), 32'(expLine));
			prevLine = vCount;
			lineCycles = 0;
			repeat (8)
			begin
				@(negedge CLK_24M);	// Fix slot plus capture
				lineCycles++;
			end
			data = shadow[fixEntryAddr(col, expLine[7:3])];
			checkValue("fixTileNb", 32'(fixTileNb), 32'(data[11:0]));
			checkValue("fixPalNb", 32'(fixPalNb), 32'(data[15:12]));
		end

		$display("Closing: %0d value mismatches, %0d assertion failures",
			errCount, i_dut.i_assertions.failCount);
		if (errCount == 0 && i_dut.i_assertions.failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (watchdogCycles) @(posedge CLK_24M);
		$display("Watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== testbench/slowVram_assertions.sv ====
`include "lspc_macros.svh"

module slowVram_assertions (
	input  logic CLK_24M,
	input  logic rstN,
	input  logic psel,
	input  logic pready,
	input  lspcPkg::slotT slot,
	input  logic cpuReq,
	input  logic cpuAck,
	input  logic cpuWrite,
	input  lspcPkg::vramDataT cpuWrData,
	input  logic ramWrEn
);
	import lspcPkg::*;

	int failCount = 0;	// Assertion failures so far
	logic [7:0] waitCycles;	// Cycles the current transfer has waited

	always_ff @(posedge CLK_24M or negedge rstN)
	begin
		if (!rstN)
			waitCycles <= '0;
		else if (!psel || pready)
			waitCycles <= '0;	// Idle or finishing
		else
			waitCycles <= waitCycles + 8'd1;
	end

	// No transfer can end under reset
	resetQuiet: assert property (@(posedge CLK_24M) !rstN |-> !pready)
		else begin $error("pready high while rstN is low"); failCount++; end

	// Back-pressure is bounded from the setup phase on
	ackLimit: assert property (@(posedge CLK_24M) disable iff (!rstN)
		psel |-> waitCycles < 8'(`ACK_LIMIT))
		else begin $error("pready did not rise within the wait limit"); failCount++; end

	ackInFix: assert property (@(posedge CLK_24M) disable iff (!rstN) cpuAck |-> slot == SLOT_FIX)
		else begin $error("cpuAck outside slot FIX"); failCount++; end

	ackPulse: assert property (@(posedge CLK_24M) disable iff (!rstN) cpuAck |=> !cpuAck)
		else begin $error("cpuAck longer than one cycle"); failCount++; end

	// Host writes only ever land in their own slot
	wrInCpu: assert property (@(posedge CLK_24M) disable iff (!rstN) ramWrEn |-> slot == SLOT_CPU)
		else begin $error("ramWrEn outside slot CPU"); failCount++; end

	reqHeld: assert property (@(posedge CLK_24M) disable iff (!rstN) cpuReq && !cpuAck |=> cpuReq)
		else begin $error("cpuReq dropped before cpuAck"); failCount++; end

	reqStable: assert property (@(posedge CLK_24M) disable iff (!rstN)
		cpuReq && !cpuAck |=> $stable(cpuWrite) && $stable(cpuWrData))
		else begin $error("cpuWrite or cpuWrData moved while waiting"); failCount++; end

endmodule

bind slowVramTop slowVram_assertions i_assertions (
	.CLK_24M(CLK_24M), .rstN(rstN), .psel(psel), .pready(pready), .slot(slot),
	.cpuReq(cpuReq), .cpuAck(cpuAck), .cpuWrite(cpuWrite), .cpuWrData(cpuWrData),
	.ramWrEn(ramWrEn)
);
